//--- source/cyc_params.svh
// ----------------------------------------------------------
// Memory cycle subsystem parameters
// Widths, region bounds, wait states and RAM depth
// ----------------------------------------------------------
`ifndef CYC_PARAMS_SVH
`define CYC_PARAMS_SVH

// Bus widths
`define CYC_AW          10          // Word address bits
`define CYC_DW          16          // Data word bits
`define CYC_MEM_WORDS   1024        // RAM depth in words

// Address map
`define CYC_FAST_TOP    10'h0FF     // Last short-cycle address
`define CYC_SLOW_BASE   10'h300     // First slow I/O address

// Extra wait states per cycle class
`define CYC_WS_SHORT    3'd0
`define CYC_WS_NORMAL   3'd1
`define CYC_WS_SLOW     3'd5

`define CYC_CNT_W       8           // DMA word count bits

`endif

//--- source/cyc_pkg.sv
// ----------------------------------------------------------
// Shared types of the memory cycle subsystem
// Request records, command records and FSM encodings
// ----------------------------------------------------------
`include "cyc_params.svh"

package cyc_pkg;

    typedef logic [`CYC_AW-1:0]    addr_t;   // Word address
    typedef logic [`CYC_DW-1:0]    data_t;   // Data word
    typedef logic [`CYC_CNT_W-1:0] cnt_t;    // DMA words left
    typedef logic [2:0]            wait_t;   // Wait-state counter

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;                         // 1 = write, 0 = read
    } bus_req_t;                              // 27 bits

    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;
        logic  brk;                           // Forces slow cycle
    } cpu_req_t;                              // 28 bits

    typedef struct packed {
        addr_t src;                           // First source word
        addr_t dst;                           // First destination word
        cnt_t  count;                         // Words to copy
    } dma_cmd_t;                              // 28 bits

    typedef enum logic [1:0] {CLS_SHORT, CLS_NORMAL, CLS_SLOW} cyc_class_e;

    typedef enum logic [2:0] {
        CYC_IDLE, CYC_BUSWAIT, CYC_HOLD, CYC_TERM, CYC_RELEASE
    } cyc_state_e;

    typedef enum logic [2:0] {
        DMA_IDLE, DMA_RD, DMA_WR, DMA_NEXT, DMA_DONE
    } dma_state_e;

    typedef enum logic [1:0] {ARB_IDLE, ARB_ACCESS, ARB_HELD} arb_state_e;

endpackage

//--- source/cycle_ctl.sv
// ----------------------------------------------------------
// CPU cycle control state counter
// Classifies each access by region, waits for the bus grant,
// holds the bus for the class wait states, then terminates
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "cyc_params.svh"

module cycle_ctl (
    input  logic              CK,
    input  logic              arst_n,
    input  logic              cpu_req,     // Four-phase CPU request
    input  cyc_pkg::cpu_req_t cpu_cmd,     // Stable while cpu_req high
    output logic              cpu_ack,
    output cyc_pkg::data_t    cpu_rdata,   // Valid with cpu_ack
    output logic              bus_req,     // Held for the whole cycle
    output cyc_pkg::bus_req_t bus_cmd,
    input  logic              bus_ack,
    input  cyc_pkg::data_t    bus_rdata
);

    cyc_pkg::cyc_state_e state;            // Cycle state counter
    cyc_pkg::cyc_class_e cls;              // Class of incoming access
    cyc_pkg::wait_t      ws_load;          // Wait states for that class
    cyc_pkg::wait_t      wait_cnt;         // Remaining wait states

    // Region decode on the incoming command
    always_comb begin
        if (cpu_cmd.brk) begin
            cls = cyc_pkg::CLS_SLOW;       // Break cycle, slow length
        end else if (cpu_cmd.addr <= `CYC_FAST_TOP) begin
            cls = cyc_pkg::CLS_SHORT;      // Fast region
        end else if (cpu_cmd.addr >= `CYC_SLOW_BASE) begin
            cls = cyc_pkg::CLS_SLOW;       // I/O region
        end else begin
            cls = cyc_pkg::CLS_NORMAL;
        end
    end

    always_comb begin
        case (cls)
            cyc_pkg::CLS_SHORT:  ws_load = `CYC_WS_SHORT;
            cyc_pkg::CLS_NORMAL: ws_load = `CYC_WS_NORMAL;
            default:             ws_load = `CYC_WS_SLOW;
        endcase
    end

    // State counter
    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= cyc_pkg::CYC_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                cyc_pkg::CYC_IDLE: begin
                    if (cpu_req) begin
                        state    <= cyc_pkg::CYC_BUSWAIT;  // Request bus next
                        wait_cnt <= ws_load;
                    end
                end
                cyc_pkg::CYC_BUSWAIT: begin
                    // Wait for grant, skip HOLD on zero wait states
                    if (bus_ack) begin
                        if (wait_cnt == '0) begin
                            state <= cyc_pkg::CYC_TERM;
                        end else begin
                            state <= cyc_pkg::CYC_HOLD;
                        end
                    end
                end
                cyc_pkg::CYC_HOLD: begin
                    wait_cnt <= wait_cnt - cyc_pkg::wait_t'(1);
                    if (wait_cnt == cyc_pkg::wait_t'(1)) begin
                        state <= cyc_pkg::CYC_TERM;        // Last wait state
                    end
                end
                cyc_pkg::CYC_TERM: begin
                    if (!cpu_req) begin
                        state <= cyc_pkg::CYC_RELEASE;     // CPU side done
                    end
                end
                cyc_pkg::CYC_RELEASE: begin
                    if (!bus_ack) begin
                        state <= cyc_pkg::CYC_IDLE;        // Arbiter let go
                    end
                end
                default: state <= cyc_pkg::CYC_IDLE;
            endcase
        end
    end

    // Command and read data registers
    always_ff @(posedge CK) begin
        if (state == cyc_pkg::CYC_IDLE && cpu_req) begin
            bus_cmd.addr  <= cpu_cmd.addr;
            bus_cmd.wdata <= cpu_cmd.wdata;
            bus_cmd.write <= cpu_cmd.write;
        end
        if (state == cyc_pkg::CYC_BUSWAIT && bus_ack) begin
            cpu_rdata <= bus_rdata;                  // Data comes with grant ack
        end
    end

    assign bus_req = (state == cyc_pkg::CYC_BUSWAIT) || (state == cyc_pkg::CYC_HOLD);
    assign cpu_ack = (state == cyc_pkg::CYC_TERM);

    // A new bus cycle starts only once the CPU ack and the last bus ack are down
    a_req_after_ack: assert property (
        @(posedge CK) disable iff (!arst_n)
        $rose(bus_req) |-> !$past(cpu_ack) && !$past(bus_ack)
    ) else $error("bus_req rose while cpu_ack or bus_ack was high");

    // Termination only after the arbiter served the cycle
    a_ack_after_bus: assert property (
        @(posedge CK) disable iff (!arst_n)
        $rose(cpu_ack) |-> $past(bus_ack)
    ) else $error("cpu_ack rose without bus_ack");

endmodule

//--- source/dma_channel.sv
// ----------------------------------------------------------
// DMA block copy channel
// Reads each word from the source and writes it to the
// destination through the shared bus
// ----------------------------------------------------------
`timescale 1ns/1ns

module dma_channel (
    input  logic              CK,
    input  logic              arst_n,
    input  logic              dma_req,     // Four-phase block request
    input  cyc_pkg::dma_cmd_t dma_cmd,
    output logic              dma_ack,     // Block copied
    output logic              bus_req,
    output cyc_pkg::bus_req_t bus_cmd,
    input  logic              bus_ack,
    input  cyc_pkg::data_t    bus_rdata
);

    cyc_pkg::dma_state_e state;
    cyc_pkg::addr_t      src_q;            // Next source address
    cyc_pkg::addr_t      dst_q;            // Next destination address
    cyc_pkg::cnt_t       left_q;           // Words still to copy
    cyc_pkg::data_t      buf_q;            // Word in flight
    logic                ack_seen;         // Bus ack taken, waiting for it to fall

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            state    <= cyc_pkg::DMA_IDLE;
            left_q   <= '0;
            ack_seen <= 1'b0;
        end else begin
            case (state)
                cyc_pkg::DMA_IDLE: begin
                    if (dma_req) begin
                        left_q <= dma_cmd.count;
                        // Zero count acks without touching the bus
                        state  <= (dma_cmd.count == '0) ? cyc_pkg::DMA_DONE
                                                        : cyc_pkg::DMA_RD;
                    end
                end
                cyc_pkg::DMA_RD, cyc_pkg::DMA_WR: begin
                    if (!ack_seen && bus_ack) begin
                        ack_seen <= 1'b1;          // Drop req
                    end else if (ack_seen && !bus_ack) begin
                        ack_seen <= 1'b0;          // Handshake closed
                        state    <= (state == cyc_pkg::DMA_RD) ? cyc_pkg::DMA_WR
                                                               : cyc_pkg::DMA_NEXT;
                    end
                end
                cyc_pkg::DMA_NEXT: begin
                    left_q <= left_q - cyc_pkg::cnt_t'(1);
                    state  <= (left_q == cyc_pkg::cnt_t'(1)) ? cyc_pkg::DMA_DONE
                                                             : cyc_pkg::DMA_RD;
                end
                cyc_pkg::DMA_DONE: begin
                    if (!dma_req) begin
                        state <= cyc_pkg::DMA_IDLE;
                    end
                end
                default: state <= cyc_pkg::DMA_IDLE;
            endcase
        end
    end

    // Address and data path
    always_ff @(posedge CK) begin
        if (state == cyc_pkg::DMA_IDLE && dma_req) begin
            src_q <= dma_cmd.src;
            dst_q <= dma_cmd.dst;
        end
        if (state == cyc_pkg::DMA_RD && !ack_seen && bus_ack) begin
            buf_q <= bus_rdata;                  // Capture source word
        end
        if (state == cyc_pkg::DMA_NEXT) begin
            src_q <= src_q + cyc_pkg::addr_t'(1);
            dst_q <= dst_q + cyc_pkg::addr_t'(1);
        end
    end

    always_comb begin
        bus_cmd.addr  = (state == cyc_pkg::DMA_WR) ? dst_q : src_q;
        bus_cmd.wdata = buf_q;
        bus_cmd.write = (state == cyc_pkg::DMA_WR);
    end

    assign bus_req = ((state == cyc_pkg::DMA_RD) || (state == cyc_pkg::DMA_WR)) && !ack_seen;
    assign dma_ack = (state == cyc_pkg::DMA_DONE);

    // Arbiter may sample the command in any cycle of the request
    a_cmd_stable: assert property (
        @(posedge CK) disable iff (!arst_n)
        bus_req && $past(bus_req) |-> $stable(bus_cmd)
    ) else $error("DMA bus_cmd changed during request");

endmodule

//--- source/mem_arbiter.sv
// ----------------------------------------------------------
// Two-master round-robin bus arbiter
// Grants the RAM to one master, performs one access and
// keeps the bus with the owner until its request falls
// ----------------------------------------------------------
`timescale 1ns/1ns

module mem_arbiter (
    input  logic              CK,
    input  logic              arst_n,
    input  logic              m0_req,      // CPU cycle controller
    input  cyc_pkg::bus_req_t m0_cmd,
    output logic              m0_ack,
    output cyc_pkg::data_t    m0_rdata,
    input  logic              m1_req,      // DMA channel
    input  cyc_pkg::bus_req_t m1_cmd,
    output logic              m1_ack,
    output cyc_pkg::data_t    m1_rdata,
    output logic              mem_en,
    output logic              mem_we,
    output cyc_pkg::addr_t    mem_addr,
    output cyc_pkg::data_t    mem_wdata,
    input  cyc_pkg::data_t    mem_rdata    // One cycle after mem_en
);

    cyc_pkg::arb_state_e state;
    logic                owner;            // Current or last served master
    logic                pick;             // Winner from IDLE
    logic                own_req;
    cyc_pkg::bus_req_t   own_cmd;

    // Round robin, the master not served last wins a tie
    always_comb begin
        if (m0_req && m1_req) begin
            pick = ~owner;
        end else begin
            pick = m1_req;
        end
    end

    assign own_req = owner ? m1_req : m0_req;
    assign own_cmd = owner ? m1_cmd : m0_cmd;

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            state  <= cyc_pkg::ARB_IDLE;
            owner  <= 1'b1;                      // m0 first after reset
            m0_ack <= 1'b0;
            m1_ack <= 1'b0;
        end else begin
            case (state)
                cyc_pkg::ARB_IDLE: begin
                    if (m0_req || m1_req) begin
                        owner <= pick;           // Grant
                        state <= cyc_pkg::ARB_ACCESS;
                    end
                end
                cyc_pkg::ARB_ACCESS: begin
                    state  <= cyc_pkg::ARB_HELD;   // RAM output valid now
                    m0_ack <= ~owner;
                    m1_ack <= owner;
                end
                cyc_pkg::ARB_HELD: begin
                    if (!own_req) begin
                        state  <= cyc_pkg::ARB_IDLE;
                        m0_ack <= 1'b0;
                        m1_ack <= 1'b0;
                    end
                end
                default: state <= cyc_pkg::ARB_IDLE;
            endcase
        end
    end

    // Single RAM access in the grant cycle
    assign mem_en    = (state == cyc_pkg::ARB_ACCESS);
    assign mem_we    = mem_en && own_cmd.write;
    assign mem_addr  = own_cmd.addr;
    assign mem_wdata = own_cmd.wdata;

    // RAM holds its output until the next access, steer it to the owner
    assign m0_rdata = owner ? '0 : mem_rdata;
    assign m1_rdata = owner ? mem_rdata : '0;

    a_one_owner: assert property (
        @(posedge CK) disable iff (!arst_n)
        !(m0_ack && m1_ack)
    ) else $error("m0_ack and m1_ack high together");

    // An ack goes only to a master that is asking for the bus
    a_ack_to_req: assert property (
        @(posedge CK) disable iff (!arst_n)
        !($rose(m0_ack) && !m0_req) && !($rose(m1_ack) && !m1_req)
    ) else $error("Bus ack given to a master without a request");

endmodule

//--- source/mem_bank.sv
// ----------------------------------------------------------
// Synchronous single-port RAM
// Write stores the word, read registers it for one cycle
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "cyc_params.svh"

module mem_bank (
    input  logic           CK,
    input  logic           mem_en,         // Access strobe from arbiter
    input  logic           mem_we,         // Write when set, read otherwise
    input  cyc_pkg::addr_t mem_addr,
    input  cyc_pkg::data_t mem_wdata,
    output cyc_pkg::data_t mem_rdata       // Valid one cycle after mem_en
);

    cyc_pkg::data_t mem [`CYC_MEM_WORDS];  // Storage, not cleared

    always_ff @(posedge CK) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];  // Held until next read
            end
        end
    end

endmodule

//--- source/cyc_top.sv
// ----------------------------------------------------------
// Memory cycle subsystem top level
// CPU cycle controller and DMA channel share one RAM
// through the round-robin arbiter
// ----------------------------------------------------------
`timescale 1ns/1ns

module cyc_top (
    input  logic              CK,
    input  logic              arst_n,
    input  logic              cpu_req,
    input  cyc_pkg::cpu_req_t cpu_cmd,
    output logic              cpu_ack,
    output cyc_pkg::data_t    cpu_rdata,
    input  logic              dma_req,
    input  cyc_pkg::dma_cmd_t dma_cmd,
    output logic              dma_ack
);

    // Arbiter port m0, cycle controller
    logic              cc_bus_req;
    cyc_pkg::bus_req_t cc_bus_cmd;
    logic              cc_bus_ack;
    cyc_pkg::data_t    cc_bus_rdata;

    // Arbiter port m1, DMA
    logic              dma_bus_req;
    cyc_pkg::bus_req_t dma_bus_cmd;
    logic              dma_bus_ack;
    cyc_pkg::data_t    dma_bus_rdata;

    // RAM port
    logic              mem_en;
    logic              mem_we;
    cyc_pkg::addr_t    mem_addr;
    cyc_pkg::data_t    mem_wdata;
    cyc_pkg::data_t    mem_rdata;

    cycle_ctl u_cycle_ctl (
        .CK       (CK),
        .arst_n   (arst_n),
        .cpu_req  (cpu_req),
        .cpu_cmd  (cpu_cmd),
        .cpu_ack  (cpu_ack),
        .cpu_rdata(cpu_rdata),
        .bus_req  (cc_bus_req),
        .bus_cmd  (cc_bus_cmd),
        .bus_ack  (cc_bus_ack),
        .bus_rdata(cc_bus_rdata)
    );

    dma_channel u_dma_channel (
        .CK       (CK),
        .arst_n   (arst_n),
        .dma_req  (dma_req),
        .dma_cmd  (dma_cmd),
        .dma_ack  (dma_ack),
        .bus_req  (dma_bus_req),
        .bus_cmd  (dma_bus_cmd),
        .bus_ack  (dma_bus_ack),
        .bus_rdata(dma_bus_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .CK       (CK),
        .arst_n   (arst_n),
        .m0_req   (cc_bus_req),
        .m0_cmd   (cc_bus_cmd),
        .m0_ack   (cc_bus_ack),
        .m0_rdata (cc_bus_rdata),
        .m1_req   (dma_bus_req),
        .m1_cmd   (dma_bus_cmd),
        .m1_ack   (dma_bus_ack),
        .m1_rdata (dma_bus_rdata),
        .mem_en   (mem_en),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    mem_bank u_mem_bank (
        .CK       (CK),
        .mem_en   (mem_en),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

endmodule

//--- verif/cyc_tb.sv
// ----------------------------------------------------------
// Memory cycle subsystem testbench
// Random CPU and DMA traffic checked against a RAM model
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "cyc_params.svh"

module cyc_tb;

    localparam int WAIT_LIMIT = 20000;            // Cycles per wait loop

    logic              CK;
    logic              arst_n;
    logic              cpu_req;
    cyc_pkg::cpu_req_t cpu_cmd;
    logic              cpu_ack;
    cyc_pkg::data_t    cpu_rdata;
    logic              dma_req;
    cyc_pkg::dma_cmd_t dma_cmd;
    logic              dma_ack;

    cyc_pkg::data_t ref_mem [`CYC_MEM_WORDS];     // RAM model
    bit             known [`CYC_MEM_WORDS];       // Word written at least once
    integer         seed;
    int             errors;
    int             checks;
    int             tests_run;
    int             tests_failed;
    int             errors_at_start;

    cyc_top uut (
        .CK       (CK),
        .arst_n   (arst_n),
        .cpu_req  (cpu_req),
        .cpu_cmd  (cpu_cmd),
        .cpu_ack  (cpu_ack),
        .cpu_rdata(cpu_rdata),
        .dma_req  (dma_req),
        .dma_cmd  (dma_cmd),
        .dma_ack  (dma_ack)
    );

    initial begin
        CK = 1'b0;
        forever #4 CK = ~CK;                      // 8 ns period
    end

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // 0 fast, 1 normal, 2 slow I/O
    function automatic cyc_pkg::addr_t addr_in_region(int region);
        int unsigned lo;
        int unsigned span;
        case (region)
            0: begin
                lo   = 0;
                span = int'(`CYC_FAST_TOP) + 1;
            end
            1: begin
                lo   = int'(`CYC_FAST_TOP) + 1;
                span = int'(`CYC_SLOW_BASE) - lo;
            end
            default: begin
                lo   = int'(`CYC_SLOW_BASE);
                span = `CYC_MEM_WORDS - lo;
            end
        endcase
        return cyc_pkg::addr_t'(lo + rand_below(span));
    endfunction

    // Expected cycles from cpu_req rise to cpu_ack rise on an idle bus
    function automatic int cycle_length(cyc_pkg::addr_t addr, logic brk);
        cyc_pkg::cyc_class_e cls;
        if (brk || addr >= `CYC_SLOW_BASE) begin
            cls = cyc_pkg::CLS_SLOW;              // Break behaves as I/O
        end else if (addr <= `CYC_FAST_TOP) begin
            cls = cyc_pkg::CLS_SHORT;
        end else begin
            cls = cyc_pkg::CLS_NORMAL;
        end
        case (cls)
            cyc_pkg::CLS_SHORT:  return 4 + int'(`CYC_WS_SHORT);
            cyc_pkg::CLS_NORMAL: return 4 + int'(`CYC_WS_NORMAL);
            default:             return 4 + int'(`CYC_WS_SLOW);
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout, %s did not happen within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
    endtask

    // One four-phase CPU access, cycles counted from the req edge
    task automatic cpu_access(input cyc_pkg::addr_t addr, input cyc_pkg::data_t wdata,
                              input logic write, input logic brk,
                              output cyc_pkg::data_t rdata, output int cycles);
        cyc_pkg::cpu_req_t cmd;
        int                n;
        bit                done;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.write = write;
        cmd.brk   = brk;
        rdata     = '0;
        cycles    = -1;
        @(posedge CK);
        cpu_req <= 1'b1;
        cpu_cmd <= cmd;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge CK);
            n++;
            done = cpu_ack;
        end
        cpu_req <= 1'b0;
        if (!done) begin
            report_timeout($sformatf("cpu_ack for address %h", addr));
        end else begin
            rdata  = cpu_rdata;
            cycles = n - 1;                       // Seen one edge after it rose
            if (write) begin
                ref_mem[addr] = wdata;
                known[addr]   = 1'b1;
            end
            @(posedge CK);
            check_value("cpu_ack one cycle after cpu_req fell", cpu_ack, 1);
            n = 0;
            while (cpu_ack && n < WAIT_LIMIT) begin
                @(posedge CK);
                n++;
            end
            if (cpu_ack) begin
                report_timeout("cpu_ack fall");
            end
        end
    endtask

    // Block copy, model follows once dma_ack is seen
    task automatic dma_run(input int src, input int dst, input int count);
        cyc_pkg::dma_cmd_t cmd;
        int                n;
        bit                done;
        cmd.src   = cyc_pkg::addr_t'(src);
        cmd.dst   = cyc_pkg::addr_t'(dst);
        cmd.count = cyc_pkg::cnt_t'(count);
        @(posedge CK);
        dma_req <= 1'b1;
        dma_cmd <= cmd;
        n    = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge CK);
            n++;
            done = dma_ack;
        end
        dma_req <= 1'b0;
        if (!done) begin
            report_timeout("dma_ack");
        end else begin
            for (int i = 0; i < count; i++) begin
                ref_mem[dst + i] = ref_mem[src + i];  // Ranges never overlap
                known[dst + i]   = known[src + i];
            end
            @(posedge CK);
            check_value("dma_ack one cycle after dma_req fell", dma_ack, 1);
            n = 0;
            while (dma_ack && n < WAIT_LIMIT) begin
                @(posedge CK);
                n++;
            end
            if (dma_ack) begin
                report_timeout("dma_ack fall");
            end
        end
    endtask

    task automatic fill_words(input int base, input int count);
        cyc_pkg::data_t rd;
        int             cyc;
        for (int i = 0; i < count; i++) begin
            cpu_access(cyc_pkg::addr_t'(base + i), cyc_pkg::data_t'($random(seed)),
                       1'b1, 1'b0, rd, cyc);
        end
    endtask

    task automatic compare_words(input int base, input int count);
        cyc_pkg::data_t rd;
        int             cyc;
        for (int i = 0; i < count; i++) begin
            cpu_access(cyc_pkg::addr_t'(base + i), '0, 1'b0, 1'b0, rd, cyc);
            check_value($sformatf("cpu_rdata at %h", base + i), rd, ref_mem[base + i]);
        end
    endtask

    task automatic write_then_read();
        cyc_pkg::addr_t addrs[$];
        cyc_pkg::addr_t a;
        cyc_pkg::data_t rd;
        int             cyc;
        begin_test();
        for (int i = 0; i < 36; i++) begin
            a = addr_in_region(i % 3);
            cpu_access(a, cyc_pkg::data_t'($random(seed)), 1'b1, 1'b0, rd, cyc);
            addrs.push_back(a);
        end
        foreach (addrs[i]) begin
            cpu_access(addrs[i], '0, 1'b0, 1'b0, rd, cyc);
            check_value($sformatf("cpu_rdata at %h", addrs[i]), rd, ref_mem[addrs[i]]);
        end
        end_test("write then read");
    endtask

    task automatic cycle_lengths();
        cyc_pkg::addr_t a;
        cyc_pkg::data_t rd;
        int             cyc;
        logic           wr;
        logic           b;
        begin_test();
        for (int region = 0; region < 3; region++) begin
            for (int brk = 0; brk < 2; brk++) begin
                b = brk[0];
                repeat (3) begin
                    a  = addr_in_region(region);
                    wr = !known[a] || (rand_below(2) == 0);  // Reads only of known words
                    cpu_access(a, cyc_pkg::data_t'($random(seed)), wr, b, rd, cyc);
                    check_value($sformatf("cpu_ack latency at %h brk %0d", a, b),
                                cyc, cycle_length(a, b));
                    if (!wr) begin
                        check_value($sformatf("cpu_rdata at %h", a), rd, ref_mem[a]);
                    end
                end
            end
        end
        end_test("cycle length by class");
    endtask

    task automatic dma_block_copy();
        int cnt;
        int lo;
        int hi;
        begin_test();
        cnt = 1 + rand_below(40);
        lo  = rand_below(512 - 40);               // Lower half
        hi  = 512 + rand_below(512 - 40);         // Upper half
        if (rand_below(2) == 0) begin
            fill_words(lo, cnt);
            dma_run(lo, hi, cnt);
            compare_words(hi, cnt);
        end else begin
            fill_words(hi, cnt);
            dma_run(hi, lo, cnt);
            compare_words(lo, cnt);
        end
        end_test("DMA block copy");
    endtask

    task automatic bus_contention();
        cyc_pkg::addr_t a;
        cyc_pkg::data_t rd;
        int             cyc;
        int             cnt;
        int             src;
        int             dst;
        begin_test();
        cnt = 16 + rand_below(16);
        src = rand_below(128 - cnt);              // DMA stays below 0x100
        dst = 128 + rand_below(128 - cnt);
        fill_words(src, cnt);
        fork
            dma_run(src, dst, cnt);
            begin
                // CPU works above 0x0FF, away from the DMA ranges
                for (int i = 0; i < 24; i++) begin
                    a = addr_in_region(1 + (i % 2));
                    if (known[a] && rand_below(2) == 0) begin
                        cpu_access(a, '0, 1'b0, 1'b0, rd, cyc);
                        check_value($sformatf("cpu_rdata at %h", a), rd, ref_mem[a]);
                    end else begin
                        cpu_access(a, cyc_pkg::data_t'($random(seed)), 1'b1, 1'b0, rd, cyc);
                    end
                end
            end
        join
        compare_words(dst, cnt);
        end_test("contention");
    endtask

    task automatic reset_and_handshake();
        cyc_pkg::addr_t a;
        int             n;
        begin_test();
        @(posedge CK);
        cpu_req <= 1'b1;
        cpu_cmd <= '0;                            // Short read of word 0
        dma_req <= 1'b1;
        dma_cmd <= '0;                            // Zero count, no bus traffic
        n = 0;
        while (!(cpu_ack && dma_ack) && n < WAIT_LIMIT) begin
            @(posedge CK);
            n++;
        end
        if (!(cpu_ack && dma_ack)) begin
            report_timeout("cpu_ack and dma_ack before reset");
        end
        arst_n <= 1'b0;                           // Both acks up, reqs still high
        @(posedge CK);
        check_value("cpu_ack in reset", cpu_ack, 0);
        check_value("dma_ack in reset", dma_ack, 0);
        cpu_req <= 1'b0;
        dma_req <= 1'b0;
        repeat (7) @(posedge CK);
        arst_n <= 1'b1;
        repeat (2) @(posedge CK);
        dma_run(rand_below(512), 512 + rand_below(512), 0);  // Acks with no copy
        a = addr_in_region(1);
        fill_words(a, 1);
        compare_words(a, 1);
        end_test("four-phase protocol and reset");
    endtask

    initial begin
        seed         = 11670;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        arst_n       = 1'b0;
        cpu_req      = 1'b0;
        cpu_cmd      = '0;
        dma_req      = 1'b0;
        dma_cmd      = '0;
        repeat (8) @(posedge CK);
        arst_n <= 1'b1;
        repeat (2) @(posedge CK);
        write_then_read();
        cycle_lengths();
        dma_block_copy();
        bus_contention();
        reset_and_handshake();
        $display("tests %0d run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/cyc_pkg.sv
source/cycle_ctl.sv
source/dma_channel.sv
source/mem_arbiter.sv
source/mem_bank.sv
source/cyc_top.sv
verif/cyc_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory cycle subsystem testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module cyc_tb -f build.f -o cyc_sim \
    && ./obj_dir/cyc_sim > sim.log 2>&1 \
    || { echo "Build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAIL, no result in sim.log"; exit 1; }
echo "PASS"
exit 0
